/* hw/lpif_pkg.sv */
/*
  shared definitions for the LPIF adapter: lane and flit widths,
  stream and protocol IDs, bring-up and link state enums, LPIF state
  codes, register addresses and reset stream IDs
*/

package lpif_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int aib_lanes = 4;

  // one bit per AIB lane
  typedef logic [aib_lanes-1:0] lane_vec_t;

  typedef logic [63:0] flit_data_t;
  typedef logic [15:0] flit_crc_t;
  typedef logic [7:0]  stream_id_t;
  typedef logic [1:0]  protid_t;
  typedef logic [3:0]  lsm_code_t;

  // wishbone word address and data
  typedef logic [1:0]  wb_addr_t;
  typedef logic [31:0] wb_data_t;

  // adapter protocol IDs
  localparam protid_t protid_cache   = 2'd0;
  localparam protid_t protid_io      = 2'd1;
  localparam protid_t protid_arb_mux = 2'd2;

  ////////////////////////////////////////////////////////////////////////////
  // state machines
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ctl_idle,
    ctl_phy_init,
    ctl_cfg,
    ctl_calib,
    ctl_wait_ca_align,
    ctl_link_up,
    ctl_phy_err
  } ctl_state_e;

  typedef enum logic [1:0] {
    lsm_reset,
    lsm_active,
    lsm_link_error
  } lsm_state_e;

  // LPIF state codes as seen on the interface
  localparam lsm_code_t lsm_code_reset     = 4'd0;
  localparam lsm_code_t lsm_code_active    = 4'd1;
  localparam lsm_code_t lsm_code_linkerror = 4'd10;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////

  localparam wb_addr_t csr_addr_cache  = 2'd0;
  localparam wb_addr_t csr_addr_io     = 2'd1;
  localparam wb_addr_t csr_addr_arb    = 2'd2;
  localparam wb_addr_t csr_addr_status = 2'd3;

  localparam stream_id_t rst_cache_id = 8'h01;
  localparam stream_id_t rst_io_id    = 8'h02;
  localparam stream_id_t rst_arb_id   = 8'h03;

endpackage

/* hw/lpif_ctl.sv */
/*
  AIB link bring-up state machine and PHY error detection,
  stream ID / protocol ID mapping in both directions,
  registered downstream and upstream flit paths
*/

`timescale 1ns/10ps

module lpif_ctl (
  input  logic                   com_clk,
  input  logic                   rst_n,
  input  logic                   lp_irdy,
  input  logic                   lp_valid,
  input  logic                   lp_crc_valid,
  input  lpif_pkg::flit_data_t   lp_data,
  input  lpif_pkg::flit_crc_t    lp_crc,
  input  lpif_pkg::stream_id_t   lp_stream,
  input  logic                   lp_linkerror,
  input  logic                   ustrm_valid,
  input  logic                   ustrm_crc_valid,
  input  lpif_pkg::flit_data_t   ustrm_data,
  input  lpif_pkg::flit_crc_t    ustrm_crc,
  input  lpif_pkg::protid_t      ustrm_protid,
  input  logic                   i_conf_done,
  input  lpif_pkg::lane_vec_t    ms_tx_transfer_en,
  input  lpif_pkg::lane_vec_t    sl_tx_transfer_en,
  input  lpif_pkg::lane_vec_t    wa_error,
  input  logic                   align_done,
  input  logic                   lsm_state_active,
  input  lpif_pkg::lsm_code_t    lsm_dstrm_state,
  input  lpif_pkg::stream_id_t   cache_id,
  input  lpif_pkg::stream_id_t   io_id,
  input  lpif_pkg::stream_id_t   arb_id,
  output logic                   dstrm_valid,
  output logic                   dstrm_crc_valid,
  output lpif_pkg::flit_data_t   dstrm_data,
  output lpif_pkg::flit_crc_t    dstrm_crc,
  output lpif_pkg::protid_t      dstrm_protid,
  output lpif_pkg::lsm_code_t    dstrm_state,
  output logic                   pl_valid,
  output logic                   pl_crc_valid,
  output lpif_pkg::flit_data_t   pl_data,
  output lpif_pkg::flit_crc_t    pl_crc,
  output lpif_pkg::stream_id_t   pl_stream,
  output logic                   ns_mac_rdy,
  output lpif_pkg::lane_vec_t    ns_adapter_rstn,
  output logic                   tx_online,
  output logic                   rx_online,
  output logic                   ctl_link_up,
  output logic                   ctl_phy_err
);

  lpif_pkg::ctl_state_e ctl_state;
  lpif_pkg::protid_t    lp_protid;
  lpif_pkg::stream_id_t ustrm_stream;
  logic                 phy_err;
  logic                 all_xfer_en;
  logic                 dstrm_accept;

  ////////////////////////////////////////////////////////////////////////////
  // bring-up and error detection
  ////////////////////////////////////////////////////////////////////////////

  assign all_xfer_en = &{ms_tx_transfer_en, sl_tx_transfer_en};

  // any lane dropping out, a word alignment error or a link layer error
  assign phy_err = ~all_xfer_en | (|wa_error) | lp_linkerror;

  assign ctl_link_up = (ctl_state == lpif_pkg::ctl_link_up);
  assign ctl_phy_err = (ctl_state == lpif_pkg::ctl_phy_err);

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctl_state       <= lpif_pkg::ctl_idle;
      ns_mac_rdy      <= 1'b0;
      ns_adapter_rstn <= '0;
      tx_online       <= 1'b0;
      rx_online       <= 1'b0;
    end else begin
      case (ctl_state)
        lpif_pkg::ctl_idle: begin
          ctl_state <= lpif_pkg::ctl_phy_init;
        end
        lpif_pkg::ctl_phy_init: begin
          if (i_conf_done) begin
            ns_mac_rdy <= 1'b1;
            ctl_state  <= lpif_pkg::ctl_cfg;
          end
        end
        lpif_pkg::ctl_cfg: begin
          // lane adapters come out of reset one cycle after mac ready
          ns_adapter_rstn <= '1;
          ctl_state       <= lpif_pkg::ctl_calib;
        end
        lpif_pkg::ctl_calib: begin
          if (all_xfer_en) begin
            tx_online <= 1'b1;
            rx_online <= 1'b1;
            ctl_state <= lpif_pkg::ctl_wait_ca_align;
          end
        end
        lpif_pkg::ctl_wait_ca_align: begin
          if (align_done) begin
            ctl_state <= lpif_pkg::ctl_link_up;
          end
        end
        lpif_pkg::ctl_link_up: begin
          if (phy_err) begin
            ctl_state <= lpif_pkg::ctl_phy_err;
          end
        end
        lpif_pkg::ctl_phy_err: begin
          // held until rst_n
          ctl_state <= lpif_pkg::ctl_phy_err;
        end
        default: begin
          ctl_state <= lpif_pkg::ctl_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stream ID mapping
  ////////////////////////////////////////////////////////////////////////////

  // unknown streams fall back to cache
  always_comb begin
    if (lp_stream == io_id) begin
      lp_protid = lpif_pkg::protid_io;
    end else if (lp_stream == arb_id) begin
      lp_protid = lpif_pkg::protid_arb_mux;
    end else begin
      lp_protid = lpif_pkg::protid_cache;
    end
    if (lp_stream == cache_id) begin
      lp_protid = lpif_pkg::protid_cache;
    end
  end

  always_comb begin
    case (ustrm_protid)
      lpif_pkg::protid_io:      ustrm_stream = io_id;
      lpif_pkg::protid_arb_mux: ustrm_stream = arb_id;
      default:                  ustrm_stream = cache_id;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // flit paths
  ////////////////////////////////////////////////////////////////////////////

  // pl_trdy is lsm_state_active
  assign dstrm_accept = lp_irdy & lsm_state_active;

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      dstrm_valid <= 1'b0;
      pl_valid    <= 1'b0;
    end else begin
      dstrm_valid <= dstrm_accept;
      pl_valid    <= ustrm_valid;
    end
  end

  // downstream payload only loads on an accepted flit
  always_ff @(posedge com_clk) begin
    if (dstrm_accept) begin
      dstrm_data      <= lp_data;
      dstrm_crc       <= lp_crc;
      dstrm_crc_valid <= lp_valid & lp_crc_valid;
      dstrm_protid    <= lp_protid;
      dstrm_state     <= lsm_dstrm_state;
    end
  end

  always_ff @(posedge com_clk) begin
    pl_data      <= ustrm_data;
    pl_crc       <= ustrm_crc;
    pl_crc_valid <= ustrm_crc_valid;
    pl_stream    <= ustrm_stream;
  end

endmodule

/* hw/lpif_lsm.sv */
/*
  LPIF link state machine: state requests from the link layer,
  pl_trdy gating and the downstream state code
*/

`timescale 1ns/10ps

module lpif_lsm (
  input  logic                com_clk,
  input  logic                rst_n,
  input  lpif_pkg::lsm_code_t lp_state_req,
  input  logic                ctl_link_up,
  input  logic                ctl_phy_err,
  output logic                pl_trdy,
  output logic                lsm_state_active,
  output lpif_pkg::lsm_code_t lsm_dstrm_state
);

  lpif_pkg::lsm_state_e lsm_state;

  ////////////////////////////////////////////////////////////////////////////
  // state register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      lsm_state <= lpif_pkg::lsm_reset;
    end else begin
      case (lsm_state)
        lpif_pkg::lsm_reset: begin
          if (ctl_phy_err) begin
            lsm_state <= lpif_pkg::lsm_link_error;
          end else if (ctl_link_up &&
                       lp_state_req == lpif_pkg::lsm_code_active) begin
            lsm_state <= lpif_pkg::lsm_active;
          end
        end
        lpif_pkg::lsm_active: begin
          // error wins over a reset request
          if (ctl_phy_err) begin
            lsm_state <= lpif_pkg::lsm_link_error;
          end else if (lp_state_req == lpif_pkg::lsm_code_reset) begin
            lsm_state <= lpif_pkg::lsm_reset;
          end
        end
        lpif_pkg::lsm_link_error: begin
          lsm_state <= lpif_pkg::lsm_link_error;
        end
        default: begin
          lsm_state <= lpif_pkg::lsm_reset;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  assign lsm_state_active = (lsm_state == lpif_pkg::lsm_active);

  // flits only flow while active
  assign pl_trdy = lsm_state_active;

  always_comb begin
    case (lsm_state)
      lpif_pkg::lsm_active:     lsm_dstrm_state = lpif_pkg::lsm_code_active;
      lpif_pkg::lsm_link_error: lsm_dstrm_state = lpif_pkg::lsm_code_linkerror;
      default:                  lsm_dstrm_state = lpif_pkg::lsm_code_reset;
    endcase
  end

endmodule

/* hw/lpif_csr.sv */
/*
  Wishbone classic slave with the three stream ID registers
  and the read-only link status word
*/

`timescale 1ns/10ps

module lpif_csr (
  input  logic                 com_clk,
  input  logic                 rst_n,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  lpif_pkg::wb_addr_t   wb_adr,
  input  lpif_pkg::wb_data_t   wb_dat_w,
  input  logic                 ctl_link_up,
  input  logic                 ctl_phy_err,
  input  lpif_pkg::lsm_code_t  lsm_dstrm_state,
  output lpif_pkg::wb_data_t   wb_dat_r,
  output logic                 wb_ack,
  output lpif_pkg::stream_id_t cache_id,
  output lpif_pkg::stream_id_t io_id,
  output lpif_pkg::stream_id_t arb_id
);

  logic               wb_req;
  logic               wb_wr;
  lpif_pkg::wb_data_t status_word;

  ////////////////////////////////////////////////////////////////////////////
  // bus handshake
  ////////////////////////////////////////////////////////////////////////////

  // new request while no ack is pending
  assign wb_req = wb_cyc & wb_stb & ~wb_ack;
  assign wb_wr  = wb_req & wb_we;

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_req;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stream ID registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      cache_id <= lpif_pkg::rst_cache_id;
      io_id    <= lpif_pkg::rst_io_id;
      arb_id   <= lpif_pkg::rst_arb_id;
    end else if (wb_wr) begin
      // status address falls through, write is dropped
      case (wb_adr)
        lpif_pkg::csr_addr_cache: cache_id <= wb_dat_w[7:0];
        lpif_pkg::csr_addr_io:    io_id    <= wb_dat_w[7:0];
        lpif_pkg::csr_addr_arb:   arb_id   <= wb_dat_w[7:0];
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////

  // state code in [7:4], phy_err in 1, link_up in 0
  assign status_word = {24'h0, lsm_dstrm_state, 2'b00, ctl_phy_err, ctl_link_up};

  always_comb begin
    case (wb_adr)
      lpif_pkg::csr_addr_cache:  wb_dat_r = {24'h0, cache_id};
      lpif_pkg::csr_addr_io:     wb_dat_r = {24'h0, io_id};
      lpif_pkg::csr_addr_arb:    wb_dat_r = {24'h0, arb_id};
      lpif_pkg::csr_addr_status: wb_dat_r = status_word;
      default:                   wb_dat_r = '0;
    endcase
  end

endmodule

/* hw/lpif_adapter_top.sv */
/*
  LPIF adapter top level: bring-up control, link state machine
  and Wishbone register block
*/

`timescale 1ns/10ps

module lpif_adapter_top (
  input  logic                 com_clk,
  input  logic                 rst_n,
  // link layer, downstream
  input  logic                 lp_irdy,
  input  logic                 lp_valid,
  input  logic                 lp_crc_valid,
  input  lpif_pkg::flit_data_t lp_data,
  input  lpif_pkg::flit_crc_t  lp_crc,
  input  lpif_pkg::stream_id_t lp_stream,
  input  lpif_pkg::lsm_code_t  lp_state_req,
  input  logic                 lp_linkerror,
  output logic                 pl_trdy,
  output logic                 dstrm_valid,
  output logic                 dstrm_crc_valid,
  output lpif_pkg::flit_data_t dstrm_data,
  output lpif_pkg::flit_crc_t  dstrm_crc,
  output lpif_pkg::protid_t    dstrm_protid,
  output lpif_pkg::lsm_code_t  dstrm_state,
  // far side, upstream
  input  logic                 ustrm_valid,
  input  logic                 ustrm_crc_valid,
  input  lpif_pkg::flit_data_t ustrm_data,
  input  lpif_pkg::flit_crc_t  ustrm_crc,
  input  lpif_pkg::protid_t    ustrm_protid,
  output logic                 pl_valid,
  output logic                 pl_crc_valid,
  output lpif_pkg::flit_data_t pl_data,
  output lpif_pkg::flit_crc_t  pl_crc,
  output lpif_pkg::stream_id_t pl_stream,
  // AIB control
  input  logic                 i_conf_done,
  input  lpif_pkg::lane_vec_t  ms_tx_transfer_en,
  input  lpif_pkg::lane_vec_t  sl_tx_transfer_en,
  input  lpif_pkg::lane_vec_t  wa_error,
  input  logic                 align_done,
  output logic                 ns_mac_rdy,
  output lpif_pkg::lane_vec_t  ns_adapter_rstn,
  output logic                 tx_online,
  output logic                 rx_online,
  // wishbone
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  lpif_pkg::wb_addr_t   wb_adr,
  input  lpif_pkg::wb_data_t   wb_dat_w,
  output lpif_pkg::wb_data_t   wb_dat_r,
  output logic                 wb_ack
);

  logic                 ctl_link_up;
  logic                 ctl_phy_err;
  logic                 lsm_state_active;
  lpif_pkg::lsm_code_t  lsm_dstrm_state;
  lpif_pkg::stream_id_t cache_id;
  lpif_pkg::stream_id_t io_id;
  lpif_pkg::stream_id_t arb_id;

  lpif_ctl u_ctl (
    .com_clk, .rst_n,
    .lp_irdy, .lp_valid, .lp_crc_valid, .lp_data, .lp_crc, .lp_stream, .lp_linkerror,
    .ustrm_valid, .ustrm_crc_valid, .ustrm_data, .ustrm_crc, .ustrm_protid,
    .i_conf_done, .ms_tx_transfer_en, .sl_tx_transfer_en, .wa_error, .align_done,
    .lsm_state_active, .lsm_dstrm_state, .cache_id, .io_id, .arb_id,
    .dstrm_valid, .dstrm_crc_valid, .dstrm_data, .dstrm_crc, .dstrm_protid, .dstrm_state,
    .pl_valid, .pl_crc_valid, .pl_data, .pl_crc, .pl_stream,
    .ns_mac_rdy, .ns_adapter_rstn, .tx_online, .rx_online,
    .ctl_link_up, .ctl_phy_err
  );

  lpif_lsm u_lsm (
    .com_clk, .rst_n,
    .lp_state_req, .ctl_link_up, .ctl_phy_err,
    .pl_trdy, .lsm_state_active, .lsm_dstrm_state
  );

  lpif_csr u_csr (
    .com_clk, .rst_n,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
    .ctl_link_up, .ctl_phy_err, .lsm_dstrm_state,
    .wb_dat_r, .wb_ack, .cache_id, .io_id, .arb_id
  );

endmodule

/* testbench/lpif_adapter_tb.sv */
/*
  testbench for the LPIF adapter: bring-up order, back-pressure,
  stream mapping, register programming and PHY error, with vectors
  from the golden file
*/

`timescale 1ns/10ps

module lpif_adapter_tb;

  localparam int wait_limit = 200;

  logic                 com_clk;
  logic                 rst_n;
  logic                 lp_irdy, lp_valid, lp_crc_valid, lp_linkerror;
  lpif_pkg::flit_data_t lp_data;
  lpif_pkg::flit_crc_t  lp_crc;
  lpif_pkg::stream_id_t lp_stream;
  lpif_pkg::lsm_code_t  lp_state_req;
  logic                 pl_trdy, dstrm_valid, dstrm_crc_valid;
  lpif_pkg::flit_data_t dstrm_data;
  lpif_pkg::flit_crc_t  dstrm_crc;
  lpif_pkg::protid_t    dstrm_protid;
  lpif_pkg::lsm_code_t  dstrm_state;
  logic                 ustrm_valid, ustrm_crc_valid;
  lpif_pkg::flit_data_t ustrm_data;
  lpif_pkg::flit_crc_t  ustrm_crc;
  lpif_pkg::protid_t    ustrm_protid;
  logic                 pl_valid, pl_crc_valid;
  lpif_pkg::flit_data_t pl_data;
  lpif_pkg::flit_crc_t  pl_crc;
  lpif_pkg::stream_id_t pl_stream;
  logic                 i_conf_done, align_done;
  lpif_pkg::lane_vec_t  ms_tx_transfer_en, sl_tx_transfer_en, wa_error;
  logic                 ns_mac_rdy, tx_online, rx_online;
  lpif_pkg::lane_vec_t  ns_adapter_rstn;
  logic                 wb_cyc, wb_stb, wb_we, wb_ack;
  lpif_pkg::wb_addr_t   wb_adr;
  lpif_pkg::wb_data_t   wb_dat_w, wb_dat_r;

  lpif_adapter_top dut0 (.*);

  initial begin
    com_clk = 1'b0;
    forever #50 com_clk = ~com_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checking and failure
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_failure();
    $display("Checks failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic timed_out(input string what);
    $display("timeout at %0t ns: %s", $time, what);
    stop_on_failure();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus and flit drivers
  ////////////////////////////////////////////////////////////////////////////

  // one wishbone classic access, called on a falling edge
  task automatic wb_access(input logic we, input lpif_pkg::wb_addr_t adr,
                           input lpif_pkg::wb_data_t wdata,
                           output lpif_pkg::wb_data_t rdata);
    int waited;
    waited = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    do begin
      @(negedge com_clk);
      waited++;
      if (waited > wait_limit) timed_out("wishbone ack never came");
    end while (!wb_ack);
    check(waited, 1, "wishbone ack latency");
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge com_clk);
    check(wb_ack, 1'b0, "wishbone ack longer than one cycle");
  endtask

  task automatic send_dstrm(input lpif_pkg::stream_id_t stream,
                            input lpif_pkg::protid_t exp_prot);
    lpif_pkg::flit_data_t data;
    lpif_pkg::flit_crc_t  crc;
    logic                 crc_valid;
    int                   waited;
    data = {$urandom, $urandom};
    crc  = 16'($urandom);
    crc_valid = 1'($urandom);
    waited = 0;
    lp_irdy      = 1'b1;
    lp_valid     = 1'b1;
    lp_crc_valid = crc_valid;
    lp_data      = data;
    lp_crc       = crc;
    lp_stream    = stream;
    // flit is held until pl_trdy, accepted on the next rising edge
    while (!pl_trdy) begin
      @(negedge com_clk);
      check(dstrm_valid, 1'b0, "dstrm_valid while pl_trdy low");
      waited++;
      if (waited > wait_limit) timed_out("pl_trdy never rose for a downstream flit");
    end
    @(negedge com_clk);
    lp_irdy  = 1'b0;
    lp_valid = 1'b0;
    check(dstrm_valid, 1'b1, "dstrm_valid after acceptance");
    check(dstrm_data, data, "dstrm_data");
    check(dstrm_crc, crc, "dstrm_crc");
    check(dstrm_crc_valid, crc_valid, "dstrm_crc_valid");
    check(dstrm_protid, exp_prot, "dstrm_protid");
    check(dstrm_state, lpif_pkg::lsm_code_active, "dstrm_state");
    @(negedge com_clk);
    check(dstrm_valid, 1'b0, "dstrm_valid without a new flit");
  endtask

  task automatic send_ustrm(input lpif_pkg::protid_t prot,
                            input lpif_pkg::stream_id_t exp_stream);
    lpif_pkg::flit_data_t data;
    lpif_pkg::flit_crc_t  crc;
    logic                 crc_valid;
    data = {$urandom, $urandom};
    crc  = 16'($urandom);
    crc_valid = 1'($urandom);
    ustrm_valid     = 1'b1;
    ustrm_crc_valid = crc_valid;
    ustrm_data      = data;
    ustrm_crc       = crc;
    ustrm_protid    = prot;
    @(negedge com_clk);
    ustrm_valid     = 1'b0;
    ustrm_crc_valid = 1'b0;
    check(pl_valid, 1'b1, "pl_valid one cycle after ustrm_valid");
    check(pl_data, data, "pl_data");
    check(pl_crc, crc, "pl_crc");
    check(pl_crc_valid, crc_valid, "pl_crc_valid");
    check(pl_stream, exp_stream, "pl_stream");
    @(negedge com_clk);
    check(pl_valid, 1'b0, "pl_valid without a new flit");
  endtask

  // single-cycle word alignment error on one lane
  task automatic pulse_wa_error(input int lane);
    int waited;
    waited = 0;
    check(pl_trdy, 1'b1, "pl_trdy before PHY error");
    wa_error[lane] = 1'b1;
    @(negedge com_clk);
    wa_error = '0;
    while (pl_trdy) begin
      @(negedge com_clk);
      waited++;
      if (waited > wait_limit) timed_out("pl_trdy never dropped after wa_error");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    lpif_pkg::wb_data_t rdata;
    logic [7:0]         tag;
    logic [31:0]        val_a, val_b;
    int                 fd, n, ch, waited, seed, ops;
    logic               done;

    seed = $urandom(32'h46b9);
    rst_n = 1'b0;
    {lp_irdy, lp_valid, lp_crc_valid, lp_linkerror} = '0;
    lp_data = '0;
    lp_crc = '0;
    lp_stream = '0;
    lp_state_req = lpif_pkg::lsm_code_reset;
    {ustrm_valid, ustrm_crc_valid} = '0;
    ustrm_data = '0;
    ustrm_crc = '0;
    ustrm_protid = '0;
    {i_conf_done, align_done} = '0;
    ms_tx_transfer_en = '0;
    sl_tx_transfer_en = '0;
    wa_error = '0;
    {wb_cyc, wb_stb, wb_we} = '0;
    wb_adr = '0;
    wb_dat_w = '0;
    repeat (10) @(negedge com_clk);
    rst_n = 1'b1;

    // mac ready must wait for configuration done
    repeat (6) begin
      @(negedge com_clk);
      check(ns_mac_rdy, 1'b0, "ns_mac_rdy before i_conf_done");
      check(ns_adapter_rstn, 4'h0, "ns_adapter_rstn before i_conf_done");
    end
    i_conf_done = 1'b1;
    waited = 0;
    do begin
      @(negedge com_clk);
      waited++;
      if (waited > wait_limit) timed_out("ns_mac_rdy never rose after i_conf_done");
    end while (!ns_mac_rdy);
    check(ns_adapter_rstn, 4'h0, "ns_adapter_rstn together with ns_mac_rdy");
    @(negedge com_clk);
    check(ns_adapter_rstn, 4'hf, "ns_adapter_rstn one cycle after ns_mac_rdy");

    // one slave lane still disabled
    ms_tx_transfer_en = 4'hf;
    sl_tx_transfer_en = 4'h7;
    repeat (5) begin
      @(negedge com_clk);
      check(tx_online, 1'b0, "tx_online with a transfer enable low");
      check(rx_online, 1'b0, "rx_online with a transfer enable low");
    end
    sl_tx_transfer_en = 4'hf;
    waited = 0;
    do begin
      @(negedge com_clk);
      waited++;
      if (waited > wait_limit) timed_out("tx_online never rose after transfer enables");
    end while (!tx_online);
    check(rx_online, 1'b1, "rx_online with tx_online");

    wb_access(1'b0, lpif_pkg::csr_addr_status, '0, rdata);
    check(rdata[0], 1'b0, "status link_up before align_done");
    align_done = 1'b1;
    waited = 0;
    do begin
      wb_access(1'b0, lpif_pkg::csr_addr_status, '0, rdata);
      waited++;
      if (waited > wait_limit) timed_out("status link_up never set after align_done");
    end while (!rdata[0]);

    // back-pressure while the link state is still reset
    lp_irdy = 1'b1;
    lp_valid = 1'b1;
    lp_data = {$urandom, $urandom};
    repeat (8) begin
      @(negedge com_clk);
      check(pl_trdy, 1'b0, "pl_trdy before active request");
      check(dstrm_valid, 1'b0, "dstrm_valid while held off");
    end
    lp_state_req = lpif_pkg::lsm_code_active;
    send_dstrm(lpif_pkg::rst_io_id, 2'd1);
    send_dstrm(lpif_pkg::rst_arb_id, 2'd2);
    send_dstrm(lpif_pkg::rst_cache_id, 2'd0);

    ////////////////////////////////////////////////////////////////////////
    // golden vectors
    ////////////////////////////////////////////////////////////////////////

    fd = $fopen("testbench/lpif_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/lpif_golden.txt");
      stop_on_failure();
    end
    ops = 0;
    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, " %c", tag);
      if (n != 1) begin
        done = 1'b1;
      end else if (tag == "#") begin
        ch = 0;
        while (ch != "\n" && ch != -1) ch = $fgetc(fd);
      end else begin
        n = $fscanf(fd, "%h %h", val_a, val_b);
        if (n != 2) begin
          $display("golden file line with tag %c is missing its values", tag);
          stop_on_failure();
        end
        ops++;
        case (tag)
          "W": wb_access(1'b1, val_a[1:0], val_b, rdata);
          "R": begin
            wb_access(1'b0, val_a[1:0], '0, rdata);
            check(rdata, val_b, "wishbone read data");
          end
          "D": send_dstrm(val_a[7:0], val_b[1:0]);
          "U": send_ustrm(val_a[1:0], val_b[7:0]);
          "P": pulse_wa_error(val_a);
          default: begin
            $display("golden file has an unknown tag %c", tag);
            stop_on_failure();
          end
        endcase
      end
    end
    $fclose(fd);
    check(ops > 0, 1'b1, "golden vectors applied");

    $display("All checks passed");
    $finish;
  end

endmodule

/* lpif_adapter.f */
hw/lpif_pkg.sv
hw/lpif_ctl.sv
hw/lpif_lsm.sv
hw/lpif_csr.sv
hw/lpif_adapter_top.sv
testbench/lpif_adapter_tb.sv

/* testbench/lpif_golden.txt */
# W <adr> <data> wishbone write, R <adr> <expected data> wishbone read
# D <stream> <expected protid>, U <protid> <expected stream>, P <lane> 0 wa_error pulse
R 3 00000011
R 0 00000001
R 1 00000002
R 2 00000003
D 01 0
D 02 1
D 03 2
D 7f 0
D 00 0
W 0 00000020
W 1 00000031
W 2 00000042
W 3 000000ff
R 0 00000020
R 1 00000031
R 2 00000042
R 3 00000011
D 20 0
D 31 1
D 42 2
D 02 0
U 0 20
U 1 31
U 2 42
U 3 20
P 2 0
R 3 000000a2
R 3 000000a2
